/* design/mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, memory geometry and encodings for the memory access path
// imported by the handler, bus controller, memory, bus interface and top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

    // data and address width
    localparam int XLEN = 32;

    // on-chip memory geometry, word index taken from address bits 9..2
    localparam int MEM_WORDS = 256;
    localparam int IDX_W     = $clog2(MEM_WORDS);

    // cycles busy stays high before done
    localparam int WAIT_STATES = 2;
    localparam int WAIT_W      = $clog2(WAIT_STATES + 1);

    // funct3 codes for loads and stores
    localparam logic [2:0] F3_B  = 3'd0;  // lb / sb
    localparam logic [2:0] F3_H  = 3'd1;  // lh / sh
    localparam logic [2:0] F3_W  = 3'd2;  // lw / sw
    localparam logic [2:0] F3_BU = 3'd4;  // lbu
    localparam logic [2:0] F3_HU = 3'd5;  // lhu

    // handler FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        DATA  = 2'd2
    } handler_state_t;

endpackage

/* design/mem_bus_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single memory port shared by handler, bus controller and word memory
// one instance in the top, each block takes its own modport
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface mem_bus_if import mem_pkg::*; ();

    logic            req_read;   // one-cycle pulse from handler
    logic            req_write;
    logic [XLEN-1:0] addr;       // held until done
    logic [XLEN-1:0] wdata;
    logic            busy;
    logic            done;
    logic            mem_re;     // memory enables, only in the done cycle
    logic            mem_we;
    logic [XLEN-1:0] rdata;      // valid while done is high

    modport handler (
        output req_read, req_write, addr, wdata,
        input  busy, done, rdata
    );

    modport ctrl (
        input  req_read, req_write,
        output busy, done, mem_re, mem_we
    );

    modport mem (
        input  mem_re, mem_we, addr, wdata,
        output rdata
    );

endinterface

/* design/mem_handler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core side of the memory path: picks a data access or a fetch,
// formats store and load data, freezes the core while busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_handler import mem_pkg::*; (
    input  logic            clk,
    input  logic            nrst,
    input  logic            read,
    input  logic            write,
    input  logic [2:0]      func3,
    input  logic [XLEN-1:0] data_addr,
    input  logic [XLEN-1:0] store_data,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] load_data,
    output logic [XLEN-1:0] instruction,
    output logic            freeze,
    mem_bus_if.handler      bus
);

    handler_state_t  state;
    handler_state_t  next_state;
    logic            start_data;   // issue a load or store this cycle
    logic            start_fetch;
    logic            is_load;      // kind of the data access in flight
    logic [2:0]      op_f3;        // func3 of the data access in flight
    logic [XLEN-1:0] store_fmt;
    logic [XLEN-1:0] load_fmt;

    // high from the request cycle through the done cycle
    assign freeze = (state != IDLE);

    // data ops take priority over fetch
    always_comb begin
        start_data  = 1'b0;
        start_fetch = 1'b0;
        if (state == IDLE && !bus.busy && !bus.done) begin
            if (read || write) begin
                start_data = 1'b1;
            end else begin
                start_fetch = 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_data) begin
                    next_state = DATA;
                end else if (start_fetch) begin
                    next_state = FETCH;
                end
            end
            FETCH, DATA: begin
                if (bus.done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // whole word is written, upper bits copied from the register sign
    always_comb begin
        case (func3)
            F3_B:    store_fmt = {{(XLEN-8){store_data[XLEN-1]}}, store_data[7:0]};
            F3_H:    store_fmt = {{(XLEN-16){store_data[XLEN-1]}}, store_data[15:0]};
            default: store_fmt = store_data;  // sw
        endcase
    end

    // signed loads extend with the word's top bit, not the byte's
    always_comb begin
        case (op_f3)
            F3_B:    load_fmt = {{(XLEN-8){bus.rdata[XLEN-1]}}, bus.rdata[7:0]};
            F3_H:    load_fmt = {{(XLEN-16){bus.rdata[XLEN-1]}}, bus.rdata[15:0]};
            F3_BU:   load_fmt = {{(XLEN-8){1'b0}}, bus.rdata[7:0]};
            F3_HU:   load_fmt = {{(XLEN-16){1'b0}}, bus.rdata[15:0]};
            default: load_fmt = bus.rdata;  // lw and anything else
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state         <= IDLE;
            bus.req_read  <= 1'b0;
            bus.req_write <= 1'b0;
            is_load       <= 1'b0;
            load_data     <= '0;
            instruction   <= '0;
        end else begin
            state         <= next_state;
            // write wins if the core raises both
            bus.req_read  <= start_fetch || (start_data && !write);
            bus.req_write <= start_data && write;
            if (start_data) begin
                is_load <= !write;
            end
            if (bus.done) begin
                if (state == DATA && is_load) begin
                    load_data <= load_fmt;
                end
                if (state == FETCH) begin
                    instruction <= bus.rdata;
                end
            end
        end
    end

    // address and write data latched for the whole access
    always_ff @(posedge clk) begin
        if (start_data) begin
            bus.addr  <= data_addr;
            bus.wdata <= store_fmt;
            op_f3     <= func3;
        end else if (start_fetch) begin
            bus.addr <= pc;
        end
    end

endmodule

/* design/mem_bus_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory port timing: takes one request pulse, holds busy for the
// wait states, then pulses done and enables the memory for that cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_bus_ctrl import mem_pkg::*; (
    input  logic     clk,
    input  logic     nrst,
    mem_bus_if.ctrl  bus
);

    logic [WAIT_W-1:0] wait_cnt;  // wait states elapsed
    logic              kind_wr;   // latched request kind, 1 = write

    // memory only sees an enable in the done cycle
    assign bus.mem_re = bus.done & ~kind_wr;
    assign bus.mem_we = bus.done &  kind_wr;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
            wait_cnt <= '0;
            kind_wr  <= 1'b0;
        end else begin
            bus.done <= 1'b0;  // single-cycle pulse
            if (bus.busy) begin
                if (wait_cnt == WAIT_W'(WAIT_STATES - 1)) begin
                    bus.busy <= 1'b0;
                    bus.done <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end else if ((bus.req_read || bus.req_write) && !bus.done) begin
                // new access, busy starts next cycle
                bus.busy <= 1'b1;
                wait_cnt <= '0;
                kind_wr  <= bus.req_write;
            end
        end
    end

endmodule

/* design/word_sram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word-wide on-chip memory behind the memory port
// synchronous write, combinational read gated by the read enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module word_sram import mem_pkg::*; (
    input  logic    clk,
    mem_bus_if.mem  bus
);

    logic [XLEN-1:0]  mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // low two address bits ignored, no byte lanes
    assign idx = bus.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (bus.mem_we) begin
            mem[idx] <= bus.wdata;
        end
    end

    assign bus.rdata = bus.mem_re ? mem[idx] : '0;  // zero when not reading

endmodule

/* design/mem_access_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory access path top: core-side ports on the handler,
// handler, bus controller and memory joined by one memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_access_top import mem_pkg::*; (
    input  logic            clk,
    input  logic            nrst,
    input  logic            read,
    input  logic            write,
    input  logic [2:0]      func3,
    input  logic [XLEN-1:0] data_addr,
    input  logic [XLEN-1:0] store_data,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] load_data,
    output logic [XLEN-1:0] instruction,
    output logic            freeze
);

    mem_bus_if bus ();

    mem_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .read        (read),
        .write       (write),
        .func3       (func3),
        .data_addr   (data_addr),
        .store_data  (store_data),
        .pc          (pc),
        .load_data   (load_data),
        .instruction (instruction),
        .freeze      (freeze),
        .bus         (bus.handler)
    );

    mem_bus_ctrl u_bus_ctrl (
        .clk  (clk),
        .nrst (nrst),
        .bus  (bus.ctrl)
    );

    word_sram u_sram (
        .clk (clk),
        .bus (bus.mem)
    );

endmodule

/* tb/mem_access_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench monitor on the core-side ports of the memory path
// keeps a reference copy of memory, predicts results, counts errors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mem_access_checker import mem_pkg::*; (
    input  logic            clk,
    input  logic            nrst,
    input  logic            read,
    input  logic            write,
    input  logic [2:0]      func3,
    input  logic [XLEN-1:0] data_addr,
    input  logic [XLEN-1:0] store_data,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] load_data,
    input  logic [XLEN-1:0] instruction,
    input  logic            freeze,
    input  logic [127:0]    test_name,
    output int              mismatch_count,
    output int              fault_count,
    output int              check_count
);

    localparam logic [1:0] K_STORE = 2'd0;
    localparam logic [1:0] K_LOAD  = 2'd1;
    localparam logic [1:0] K_FETCH = 2'd2;
    localparam int FREEZE_LEN = WAIT_STATES + 2;  // request cycle through done cycle

    logic [XLEN-1:0] ref_mem [MEM_WORDS];
    logic            ref_ok  [MEM_WORDS];
    logic            armed = 1'b0;      // set once reset has been seen
    logic            pending = 1'b0;    // access in flight
    logic [1:0]      p_kind;
    logic [2:0]      p_f3;
    logic [XLEN-1:0] p_addr;
    logic [XLEN-1:0] p_data;
    int              frz_cnt = 0;
    logic [XLEN-1:0] prev_load;
    logic [XLEN-1:0] prev_instr;
    int              n_mismatch = 0;
    int              n_fault = 0;
    int              n_check = 0;

    assign mismatch_count = n_mismatch;
    assign fault_count    = n_fault;
    assign check_count    = n_check;

    function automatic int word_index(input logic [XLEN-1:0] a);
        return int'((a >> 2) % MEM_WORDS);
    endfunction

    // narrow stores still write the full word, filled from the register's top bit
    function automatic logic [XLEN-1:0] store_word(input logic [2:0] f3,
                                                   input logic [XLEN-1:0] v);
        logic [XLEN-1:0] keep;
        keep = (f3 == F3_B) ? ({XLEN{1'b1}} >> (XLEN-8)) :
               (f3 == F3_H) ? ({XLEN{1'b1}} >> (XLEN-16)) : {XLEN{1'b1}};
        return v[XLEN-1] ? (v | ~keep) : (v & keep);
    endfunction

    // lb and lh fill from the word's bit 31, unsigned loads fill with zeros
    function automatic logic [XLEN-1:0] load_word(input logic [2:0] f3,
                                                  input logic [XLEN-1:0] w);
        logic [XLEN-1:0] keep;
        logic            fill;
        case (f3)
            F3_B, F3_BU: keep = {XLEN{1'b1}} >> (XLEN-8);
            F3_H, F3_HU: keep = {XLEN{1'b1}} >> (XLEN-16);
            default:     keep = {XLEN{1'b1}};
        endcase
        fill = (f3 == F3_B || f3 == F3_H) ? w[XLEN-1] : 1'b0;
        return fill ? (w | ~keep) : (w & keep);
    endfunction

    task automatic compare(input string what, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
        n_check++;
        if (act !== exp) begin
            n_mismatch++;
            $display("MISMATCH %0s %0s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic finish_access();
        int idx;
        idx = word_index(p_addr);
        compare("freeze cycles", XLEN'(FREEZE_LEN), XLEN'(frz_cnt));
        case (p_kind)
            K_STORE: begin
                ref_mem[idx] = store_word(p_f3, p_data);
                ref_ok[idx]  = 1'b1;
            end
            K_LOAD: begin
                if (ref_ok[idx]) begin
                    compare("load_data", load_word(p_f3, ref_mem[idx]), load_data);
                end else begin
                    n_fault++;
                    $display("%0s: load from address %h that was never stored", test_name, p_addr);
                end
            end
            default: begin
                if (ref_ok[idx]) begin
                    compare("instruction", ref_mem[idx], instruction);
                end
            end
        endcase
        // the result register not targeted must hold
        if (p_kind != K_LOAD) compare("load_data held", prev_load, load_data);
        if (p_kind != K_FETCH) compare("instruction held", prev_instr, instruction);
    endtask

    always @(posedge clk) begin
        if (!nrst) begin
            armed   = 1'b1;
            pending = 1'b0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                ref_ok[i] = 1'b0;
            end
            compare("freeze in reset", '0, XLEN'(freeze));
            compare("load_data in reset", '0, load_data);
            compare("instruction in reset", '0, instruction);
        end else if (armed) begin
            if (pending && !freeze) begin
                finish_access();
                pending = 1'b0;
            end
            if (!freeze) begin
                // idle handler issues an access at this edge, data op first
                pending = 1'b1;
                p_kind  = write ? K_STORE : (read ? K_LOAD : K_FETCH);
                p_f3    = func3;
                p_addr  = (p_kind == K_FETCH) ? pc : data_addr;
                p_data  = store_data;
                frz_cnt = 0;
            end else begin
                frz_cnt++;
                compare("load_data during freeze", prev_load, load_data);
                compare("instruction during freeze", prev_instr, instruction);
            end
        end
        prev_load  = load_data;
        prev_instr = instruction;
    end

endmodule

/* tb/tb_mem_access.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory access path: reset, then a table of
// stores, loads and fetches applied in order, checked by the monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_mem_access import mem_pkg::*; ();

    localparam int NUM_ROWS = 32;
    localparam int CYCLE_LIMIT = NUM_ROWS * (WAIT_STATES + 3) * 3 + 50;
    localparam logic [31:0] SEED = 32'h48b9_ebf6;
    localparam logic [1:0] OP_ST = 2'd0;
    localparam logic [1:0] OP_LD = 2'd1;
    localparam logic [1:0] OP_FE = 2'd2;

    logic            clk;
    logic            nrst;
    logic            read;
    logic            write;
    logic [2:0]      func3;
    logic [XLEN-1:0] data_addr;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] instruction;
    logic            freeze;
    logic [127:0]    test_name;
    int              mismatch_count;
    int              fault_count;
    int              check_count;
    int              cycles;

    // stimulus table
    logic [127:0]    row_name  [NUM_ROWS];
    logic [1:0]      row_op    [NUM_ROWS];
    logic [2:0]      row_f3    [NUM_ROWS];
    logic [XLEN-1:0] row_addr  [NUM_ROWS];
    logic [XLEN-1:0] row_value [NUM_ROWS];
    logic            row_rand  [NUM_ROWS];  // store value drawn at run time
    int              n_rows;

    mem_access_top dut (
        .clk         (clk),
        .nrst        (nrst),
        .read        (read),
        .write       (write),
        .func3       (func3),
        .data_addr   (data_addr),
        .store_data  (store_data),
        .pc          (pc),
        .load_data   (load_data),
        .instruction (instruction),
        .freeze      (freeze)
    );

    mem_access_checker u_checker (
        .clk            (clk),
        .nrst           (nrst),
        .read           (read),
        .write          (write),
        .func3          (func3),
        .data_addr      (data_addr),
        .store_data     (store_data),
        .pc             (pc),
        .load_data      (load_data),
        .instruction    (instruction),
        .freeze         (freeze),
        .test_name      (test_name),
        .mismatch_count (mismatch_count),
        .fault_count    (fault_count),
        .check_count    (check_count)
    );

    always #2 clk = ~clk;

    task automatic add_row(input logic [127:0] name, input logic [1:0] op,
                           input logic [2:0] f3, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] value, input logic rnd);
        row_name[n_rows]  = name;
        row_op[n_rows]    = op;
        row_f3[n_rows]    = f3;
        row_addr[n_rows]  = addr;
        row_value[n_rows] = value;
        row_rand[n_rows]  = rnd;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        add_row("sw_rand_a",   OP_ST, F3_W,  32'h010, '0,            1'b1);
        add_row("sw_rand_b",   OP_ST, F3_W,  32'h014, '0,            1'b1);
        add_row("lw_rand_a",   OP_LD, F3_W,  32'h010, '0,            1'b0);
        add_row("lw_rand_b",   OP_LD, F3_W,  32'h014, '0,            1'b0);
        add_row("sw_neg",      OP_ST, F3_W,  32'h020, 32'h8765_43a9, 1'b0);
        add_row("sw_pos",      OP_ST, F3_W,  32'h024, 32'h1234_f6c8, 1'b0);
        add_row("lb_neg",      OP_LD, F3_B,  32'h020, '0,            1'b0);
        add_row("lh_neg",      OP_LD, F3_H,  32'h020, '0,            1'b0);
        add_row("lbu_neg",     OP_LD, F3_BU, 32'h020, '0,            1'b0);
        add_row("lhu_neg",     OP_LD, F3_HU, 32'h020, '0,            1'b0);
        add_row("lw_neg",      OP_LD, F3_W,  32'h020, '0,            1'b0);
        add_row("lb_pos",      OP_LD, F3_B,  32'h024, '0,            1'b0);
        add_row("lh_pos",      OP_LD, F3_H,  32'h024, '0,            1'b0);
        add_row("lbu_pos",     OP_LD, F3_BU, 32'h024, '0,            1'b0);
        add_row("lhu_pos",     OP_LD, F3_HU, 32'h024, '0,            1'b0);
        add_row("lw_pos",      OP_LD, F3_W,  32'h024, '0,            1'b0);
        add_row("sb_neg",      OP_ST, F3_B,  32'h030, 32'h8000_00f1, 1'b0);
        add_row("lw_sb_neg",   OP_LD, F3_W,  32'h030, '0,            1'b0);
        add_row("sb_pos",      OP_ST, F3_B,  32'h034, 32'h7fff_ff85, 1'b0);
        add_row("lw_sb_pos",   OP_LD, F3_W,  32'h034, '0,            1'b0);
        add_row("sh_neg",      OP_ST, F3_H,  32'h038, 32'hc000_1234, 1'b0);
        add_row("lw_sh_neg",   OP_LD, F3_W,  32'h038, '0,            1'b0);
        add_row("sh_pos",      OP_ST, F3_H,  32'h03c, 32'h0fff_9abc, 1'b0);
        add_row("lw_sh_pos",   OP_LD, F3_W,  32'h03c, '0,            1'b0);
        add_row("fetch_a",     OP_FE, F3_W,  32'h010, '0,            1'b0);
        add_row("fetch_b",     OP_FE, F3_W,  32'h020, '0,            1'b0);
        add_row("fetch_c",     OP_FE, F3_W,  32'h03c, '0,            1'b0);
        add_row("sw_new",      OP_ST, F3_W,  32'h040, '0,            1'b1);
        add_row("fetch_new",   OP_FE, F3_W,  32'h040, '0,            1'b0);
        add_row("lw_unalign",  OP_LD, F3_W,  32'h043, '0,            1'b0);  // low bits ignored
        add_row("lw_keep_a",   OP_LD, F3_W,  32'h010, '0,            1'b0);
        add_row("lw_keep_b",   OP_LD, F3_W,  32'h014, '0,            1'b0);
    endtask

    // edge with freeze low issues the access, next freeze-low edge shows its result
    task automatic wait_access();
        @(posedge clk);
        while (freeze !== 1'b0) @(posedge clk);
        @(posedge clk);
        while (freeze !== 1'b0) @(posedge clk);
    endtask

    task automatic apply_row(input int i);
        logic [XLEN-1:0] value;
        value = row_rand[i] ? $urandom() : row_value[i];
        test_name  <= row_name[i];
        func3      <= row_f3[i];
        data_addr  <= row_addr[i];
        store_data <= value;
        read       <= (row_op[i] == OP_LD);
        write      <= (row_op[i] == OP_ST);
        if (row_op[i] == OP_FE) begin
            pc <= row_addr[i];
        end
        wait_access();
    endtask

    task automatic report_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, fault_count);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            report_counts();
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        nrst       = 1'b1;
        read       = 1'b0;
        write      = 1'b0;
        func3      = F3_W;
        data_addr  = '0;
        store_data = '0;
        pc         = '0;
        test_name  = "reset";
        cycles     = 0;
        build_table();
        @(posedge clk);
        nrst <= 1'b0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        read  <= 1'b0;
        write <= 1'b0;
        repeat (2) @(posedge clk);  // let the monitor finish the last edge
        report_counts();
        if (check_count == 0) begin
            $display("no results were compared");
        end
        if (mismatch_count == 0 && fault_count == 0 && check_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* list.f */
design/mem_pkg.sv
design/mem_bus_if.sv
design/mem_handler.sv
design/mem_bus_ctrl.sv
design/word_sram.sv
design/mem_access_top.sv
tb/mem_access_checker.sv
tb/tb_mem_access.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mem_access -f list.f \
    -o sim_mem_access > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_mem_access > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
